/* hdl/trace_pkg.sv */
`default_nettype none

package trace_pkg;

   // Number of traced cores
   localparam int NUM_CORES = 2;

   // Characters held per core before putc drops
   localparam int FIFO_DEPTH = 4;

   // Trace field widths
   localparam int REG_IDX_W = 5;
   localparam int DATA_W = 32;

   // APB address width, byte addressed
   localparam int APB_ADDR_W = 8;

   // Decoded software events
   typedef enum logic [1:0] {
      OP_NONE   = 2'd0,
      OP_EXIT   = 2'd1,
      OP_REPORT = 2'd2,
      OP_PUTC   = 2'd3
   } trace_op_e;

   // Top instruction byte of l.nop
   localparam logic [7:0] NOP_OPCODE = 8'h15;

   // l.nop immediates used as simulation hooks
   localparam logic [15:0] NOP_EXIT   = 16'h0001;
   localparam logic [15:0] NOP_REPORT = 16'h0002;
   localparam logic [15:0] NOP_PUTC   = 16'h0004;

   // Argument register of the software hooks
   localparam logic [REG_IDX_W-1:0] R3_IDX = 5'd3;

   // Register word offsets
   typedef enum logic [APB_ADDR_W-1:0] {
      REG_STATUS  = 8'h00,
      REG_EXIT0   = 8'h04,
      REG_EXIT1   = 8'h08,
      REG_REPORT0 = 8'h0C,
      REG_REPORT1 = 8'h10,
      REG_CHAR0   = 8'h14,
      REG_CHAR1   = 8'h18
   } apb_reg_e;

endpackage

`default_nettype wire

/* hdl/char_fifo.sv */
`default_nettype none

module char_fifo (
   input  logic       clk_i,
   input  logic       arst_n_i,
   input  logic       push_i,
   input  logic [7:0] push_data_i,
   input  logic       pop_i,
   input  logic       ovf_clr_i,
   output logic       valid_o,
   output logic [7:0] data_o,
   output logic       ovf_o
);

   import trace_pkg::*;

   // Storage, depth is a power of two so pointers wrap on their own
   logic [7:0]                      mem_q [FIFO_DEPTH];
   logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr_q;
   logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr_q;
   logic [$clog2(FIFO_DEPTH+1)-1:0] count_q;
   logic                            ovf_q;

   logic full;
   logic do_push;
   logic do_pop;

   assign full    = (count_q == FIFO_DEPTH);
   // A full FIFO drops the push even if a pop happens in the same cycle
   assign do_push = push_i && !full;
   assign do_pop  = pop_i && valid_o;

   assign valid_o = (count_q != '0);
   assign data_o  = mem_q[rd_ptr_q];
   assign ovf_o   = ovf_q;

   // Character storage
   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem_q[wr_ptr_q] <= push_data_i;
      end
   end

   // Pointers, fill level and sticky overflow
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         ovf_q    <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
         // A new drop wins over a clear in the same cycle
         if (push_i && full) begin
            ovf_q <= 1'b1;
         end else if (ovf_clr_i) begin
            ovf_q <= 1'b0;
         end
      end
   end

   // Fill level stays within the storage
   a_count_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      count_q <= FIFO_DEPTH);

   // The register block only pops a character it has seen
   a_pop_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      pop_i |-> valid_o);

endmodule

`default_nettype wire

/* hdl/core_trace_decoder.sv */
`default_nettype none

module core_trace_decoder (
   input  logic                           clk_i,
   input  logic                           arst_n_i,
   input  logic                           trace_valid_i,
   input  logic                           trace_wben_i,
   input  logic [trace_pkg::REG_IDX_W-1:0] trace_wbreg_i,
   input  logic [trace_pkg::DATA_W-1:0]    trace_wbdata_i,
   input  logic [trace_pkg::DATA_W-1:0]    trace_pc_i,
   input  logic [trace_pkg::DATA_W-1:0]    trace_insn_i,
   input  logic                           char_pop_i,
   input  logic                           char_ovf_clr_i,
   output logic                           evt_valid_o,
   output trace_pkg::trace_op_e           evt_op_o,
   output logic [trace_pkg::DATA_W-1:0]    evt_data_o,
   output logic                           char_valid_o,
   output logic [7:0]                     char_data_o,
   output logic                           char_ovf_o
);

   import trace_pkg::*;

   // Registered trace beat
   logic                 beat_valid_q;
   logic                 beat_wben_q;
   logic [REG_IDX_W-1:0] beat_wbreg_q;
   logic [DATA_W-1:0]    beat_wbdata_q;
   logic [DATA_W-1:0]    beat_pc_q;
   logic [DATA_W-1:0]    beat_insn_q;

   // Shadow of r3 as seen through writeback
   logic [DATA_W-1:0] r3_q;

   // Event toward the register block
   logic              evt_valid_q;
   trace_op_e         evt_op_q;
   logic [DATA_W-1:0] evt_data_q;
   // PC of the last event, for debug messages
   logic [DATA_W-1:0] last_pc_q;

   logic      beat_nop;
   logic      beat_r3_wr;
   logic      beat_evt;
   logic      beat_putc;
   trace_op_e beat_op;

   // l.nop is recognised by its top byte
   assign beat_nop   = beat_valid_q && (beat_insn_q[31:24] == NOP_OPCODE);
   assign beat_r3_wr = beat_valid_q && beat_wben_q && (beat_wbreg_q == R3_IDX);

   // Hook number sits in the 16 bit immediate
   always_comb begin
      beat_op = OP_NONE;
      if (beat_nop) begin
         case (beat_insn_q[15:0])
            NOP_EXIT:   beat_op = OP_EXIT;
            NOP_REPORT: beat_op = OP_REPORT;
            NOP_PUTC:   beat_op = OP_PUTC;
            default:    beat_op = OP_NONE;
         endcase
      end
   end

   assign beat_evt  = (beat_op == OP_EXIT) || (beat_op == OP_REPORT);
   assign beat_putc = (beat_op == OP_PUTC);

   // Input stage, payload follows the valid flag
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         beat_valid_q <= 1'b0;
      end else begin
         beat_valid_q <= trace_valid_i;
      end
   end

   always_ff @(posedge clk_i) begin
      beat_wben_q   <= trace_wben_i;
      beat_wbreg_q  <= trace_wbreg_i;
      beat_wbdata_q <= trace_wbdata_i;
      beat_pc_q     <= trace_pc_i;
      beat_insn_q   <= trace_insn_i;
   end

   // Shadow update and event capture
   // Events take r3 from before their own beat
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r3_q        <= '0;
         evt_valid_q <= 1'b0;
         evt_op_q    <= OP_NONE;
         evt_data_q  <= '0;
         last_pc_q   <= '0;
      end else begin
         if (beat_r3_wr) begin
            r3_q <= beat_wbdata_q;
         end
         evt_valid_q <= beat_evt;
         evt_op_q    <= beat_evt ? beat_op : OP_NONE;
         if (beat_evt) begin
            evt_data_q <= r3_q;
            last_pc_q  <= beat_pc_q;
         end
      end
   end

   assign evt_valid_o = evt_valid_q;
   assign evt_op_o    = evt_op_q;
   assign evt_data_o  = evt_data_q;

   // putc characters, low byte of r3
   char_fifo i_char_fifo (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .push_i      (beat_putc),
      .push_data_i (r3_q[7:0]),
      .pop_i       (char_pop_i),
      .ovf_clr_i   (char_ovf_clr_i),
      .valid_o     (char_valid_o),
      .data_o      (char_data_o),
      .ovf_o       (char_ovf_o)
   );

   // Only exit and report reach the register block
   a_evt_op: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      evt_valid_o |-> (evt_op_o == OP_EXIT) || (evt_op_o == OP_REPORT))
      else $error("event at pc %h carries op %s", last_pc_q, evt_op_o.name());

endmodule

`default_nettype wire

/* hdl/trace_apb_regs.sv */
`default_nettype none

module trace_apb_regs (
   input  logic                            clk_i,
   input  logic                            arst_n_i,
   input  logic [trace_pkg::APB_ADDR_W-1:0] paddr_i,
   input  logic                            psel_i,
   input  logic                            penable_i,
   input  logic                            pwrite_i,
   input  logic [trace_pkg::DATA_W-1:0]     pwdata_i,
   input  logic                            evt0_valid_i,
   input  trace_pkg::trace_op_e            evt0_op_i,
   input  logic [trace_pkg::DATA_W-1:0]     evt0_data_i,
   input  logic                            evt1_valid_i,
   input  trace_pkg::trace_op_e            evt1_op_i,
   input  logic [trace_pkg::DATA_W-1:0]     evt1_data_i,
   input  logic                            char0_valid_i,
   input  logic [7:0]                      char0_data_i,
   input  logic                            char0_ovf_i,
   input  logic                            char1_valid_i,
   input  logic [7:0]                      char1_data_i,
   input  logic                            char1_ovf_i,
   output logic [trace_pkg::DATA_W-1:0]     prdata_o,
   output logic                            pslverr_o,
   output logic                            char0_pop_o,
   output logic                            char1_pop_o,
   output logic                            char0_ovf_clr_o,
   output logic                            char1_ovf_clr_o,
   output logic                            done_o
);

   import trace_pkg::*;

   // Per-core views of the loose inputs
   logic [NUM_CORES-1:0] evt_valid;
   trace_op_e            evt_op [NUM_CORES];
   logic [DATA_W-1:0]    evt_data [NUM_CORES];
   logic [NUM_CORES-1:0] char_valid;
   logic [7:0]           char_data [NUM_CORES];
   logic [NUM_CORES-1:0] char_ovf;

   assign evt_valid   = {evt1_valid_i, evt0_valid_i};
   assign evt_op[0]   = evt0_op_i;
   assign evt_op[1]   = evt1_op_i;
   assign evt_data[0] = evt0_data_i;
   assign evt_data[1] = evt1_data_i;
   assign char_valid  = {char1_valid_i, char0_valid_i};
   assign char_data[0] = char0_data_i;
   assign char_data[1] = char1_data_i;
   assign char_ovf    = {char1_ovf_i, char0_ovf_i};

   // Stored results
   logic [NUM_CORES-1:0] exited_q;
   logic [DATA_W-1:0]    exit_code_q [NUM_CORES];
   logic [DATA_W-1:0]    report_q [NUM_CORES];

   // APB decode
   apb_reg_e          reg_sel;
   logic              access;
   logic              rd_access;
   logic              wr_access;
   logic              mapped;
   logic [DATA_W-1:0] rd_data;
   logic [DATA_W-1:0] status_word;

   assign reg_sel   = apb_reg_e'(paddr_i);
   assign access    = psel_i && penable_i;
   assign rd_access = access && !pwrite_i;
   assign wr_access = access && pwrite_i;

   // Event capture, a second exit overwrites the code
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         exited_q <= '0;
         for (int c = 0; c < NUM_CORES; c++) begin
            exit_code_q[c] <= '0;
            report_q[c]    <= '0;
         end
      end else begin
         for (int c = 0; c < NUM_CORES; c++) begin
            if (evt_valid[c]) begin
               case (evt_op[c])
                  OP_EXIT: begin
                     exited_q[c]    <= 1'b1;
                     exit_code_q[c] <= evt_data[c];
                  end
                  OP_REPORT: report_q[c] <= evt_data[c];
                  default: ;
               endcase
            end
         end
      end
   end

   assign done_o = &exited_q;

   // Status layout
   always_comb begin
      status_word      = '0;
      status_word[1:0] = exited_q;
      status_word[3:2] = char_valid;
      status_word[5:4] = char_ovf;
      status_word[8]   = done_o;
   end

   // Read mux, unmapped offsets fall to default
   always_comb begin
      rd_data = '0;
      mapped  = 1'b1;
      case (reg_sel)
         REG_STATUS:  rd_data = status_word;
         REG_EXIT0:   rd_data = exit_code_q[0];
         REG_EXIT1:   rd_data = exit_code_q[1];
         REG_REPORT0: rd_data = report_q[0];
         REG_REPORT1: rd_data = report_q[1];
         // Character byte reads as zero when empty
         REG_CHAR0:   rd_data[8:0] = {char_valid[0], char_valid[0] ? char_data[0] : 8'h00};
         REG_CHAR1:   rd_data[8:0] = {char_valid[1], char_valid[1] ? char_data[1] : 8'h00};
         default:     mapped = 1'b0;
      endcase
   end

   assign prdata_o  = rd_data;
   // Only STATUS is writable
   assign pslverr_o = access && (!mapped || (pwrite_i && (reg_sel != REG_STATUS)));

   // CHAR reads pop at the end of the access phase
   assign char0_pop_o = rd_access && (reg_sel == REG_CHAR0) && char_valid[0];
   assign char1_pop_o = rd_access && (reg_sel == REG_CHAR1) && char_valid[1];

   // Write 1 to clear overflow
   assign char0_ovf_clr_o = wr_access && (reg_sel == REG_STATUS) && pwdata_i[4];
   assign char1_ovf_clr_o = wr_access && (reg_sel == REG_STATUS) && pwdata_i[5];

   // Access phase follows exactly one setup phase
   a_apb_phase: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      penable_i |-> psel_i && $past(psel_i && !penable_i));

endmodule

`default_nettype wire

/* hdl/trace_monitor.sv */
`default_nettype none

module trace_monitor (
   input  logic                            clk_i,
   input  logic                            arst_n_i,
   // Core 0 writeback trace
   input  logic                            trace0_valid_i,
   input  logic                            trace0_wben_i,
   input  logic [trace_pkg::REG_IDX_W-1:0]  trace0_wbreg_i,
   input  logic [trace_pkg::DATA_W-1:0]     trace0_wbdata_i,
   input  logic [trace_pkg::DATA_W-1:0]     trace0_pc_i,
   input  logic [trace_pkg::DATA_W-1:0]     trace0_insn_i,
   // Core 1 writeback trace
   input  logic                            trace1_valid_i,
   input  logic                            trace1_wben_i,
   input  logic [trace_pkg::REG_IDX_W-1:0]  trace1_wbreg_i,
   input  logic [trace_pkg::DATA_W-1:0]     trace1_wbdata_i,
   input  logic [trace_pkg::DATA_W-1:0]     trace1_pc_i,
   input  logic [trace_pkg::DATA_W-1:0]     trace1_insn_i,
   // APB slave, zero wait states
   input  logic [trace_pkg::APB_ADDR_W-1:0] paddr_i,
   input  logic                            psel_i,
   input  logic                            penable_i,
   input  logic                            pwrite_i,
   input  logic [trace_pkg::DATA_W-1:0]     pwdata_i,
   output logic [trace_pkg::DATA_W-1:0]     prdata_o,
   output logic                            pslverr_o,
   // All cores have exited
   output logic                            done_o
);

   import trace_pkg::*;

   // Decoder to register block, one entry per core
   logic [NUM_CORES-1:0] evt_valid;
   trace_op_e            evt_op [NUM_CORES];
   logic [DATA_W-1:0]    evt_data [NUM_CORES];
   logic [NUM_CORES-1:0] char_valid;
   logic [7:0]           char_data [NUM_CORES];
   logic [NUM_CORES-1:0] char_ovf;
   logic [NUM_CORES-1:0] char_pop;
   logic [NUM_CORES-1:0] char_ovf_clr;

   core_trace_decoder i_dec0 (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .trace_valid_i  (trace0_valid_i),
      .trace_wben_i   (trace0_wben_i),
      .trace_wbreg_i  (trace0_wbreg_i),
      .trace_wbdata_i (trace0_wbdata_i),
      .trace_pc_i     (trace0_pc_i),
      .trace_insn_i   (trace0_insn_i),
      .char_pop_i     (char_pop[0]),
      .char_ovf_clr_i (char_ovf_clr[0]),
      .evt_valid_o    (evt_valid[0]),
      .evt_op_o       (evt_op[0]),
      .evt_data_o     (evt_data[0]),
      .char_valid_o   (char_valid[0]),
      .char_data_o    (char_data[0]),
      .char_ovf_o     (char_ovf[0])
   );

   core_trace_decoder i_dec1 (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .trace_valid_i  (trace1_valid_i),
      .trace_wben_i   (trace1_wben_i),
      .trace_wbreg_i  (trace1_wbreg_i),
      .trace_wbdata_i (trace1_wbdata_i),
      .trace_pc_i     (trace1_pc_i),
      .trace_insn_i   (trace1_insn_i),
      .char_pop_i     (char_pop[1]),
      .char_ovf_clr_i (char_ovf_clr[1]),
      .evt_valid_o    (evt_valid[1]),
      .evt_op_o       (evt_op[1]),
      .evt_data_o     (evt_data[1]),
      .char_valid_o   (char_valid[1]),
      .char_data_o    (char_data[1]),
      .char_ovf_o     (char_ovf[1])
   );

   // Host-visible results and done
   trace_apb_regs i_trace_apb_regs (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .paddr_i         (paddr_i),
      .psel_i          (psel_i),
      .penable_i       (penable_i),
      .pwrite_i        (pwrite_i),
      .pwdata_i        (pwdata_i),
      .evt0_valid_i    (evt_valid[0]),
      .evt0_op_i       (evt_op[0]),
      .evt0_data_i     (evt_data[0]),
      .evt1_valid_i    (evt_valid[1]),
      .evt1_op_i       (evt_op[1]),
      .evt1_data_i     (evt_data[1]),
      .char0_valid_i   (char_valid[0]),
      .char0_data_i    (char_data[0]),
      .char0_ovf_i     (char_ovf[0]),
      .char1_valid_i   (char_valid[1]),
      .char1_data_i    (char_data[1]),
      .char1_ovf_i     (char_ovf[1]),
      .prdata_o        (prdata_o),
      .pslverr_o       (pslverr_o),
      .char0_pop_o     (char_pop[0]),
      .char1_pop_o     (char_pop[1]),
      .char0_ovf_clr_o (char_ovf_clr[0]),
      .char1_ovf_clr_o (char_ovf_clr[1]),
      .done_o          (done_o)
   );

endmodule

`default_nettype wire

/* verif/tb_trace_monitor.sv */
`default_nettype none

module tb_trace_monitor;

   timeunit 1ns;
   timeprecision 1ps;

   import trace_pkg::*;

   localparam int CLK_PERIOD   = 8;
   localparam int APB_TIMEOUT  = 16;
   localparam int DONE_TIMEOUT = 64;
   // Top byte of l.addi, standing in for any non-hook instruction
   localparam logic [7:0] ALU_OPCODE = 8'h9c;

   logic clk;
   logic arst_n;

   // One trace slot per core
   logic [NUM_CORES-1:0] tr_valid;
   logic [NUM_CORES-1:0] tr_wben;
   logic [REG_IDX_W-1:0] tr_wbreg [NUM_CORES];
   logic [DATA_W-1:0]    tr_wbdata [NUM_CORES];
   logic [DATA_W-1:0]    tr_pc [NUM_CORES];
   logic [DATA_W-1:0]    tr_insn [NUM_CORES];

   // APB master side
   logic [APB_ADDR_W-1:0] paddr;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [DATA_W-1:0]     pwdata;
   logic [DATA_W-1:0]     prdata;
   logic                  pslverr;
   logic                  done;
   int                    xfer_cnt;

   // Reference model state
   integer               seed;
   logic [DATA_W-1:0]    m_r3 [NUM_CORES];
   logic [NUM_CORES-1:0] m_exited;
   logic [DATA_W-1:0]    m_exit_code [NUM_CORES];
   logic [DATA_W-1:0]    m_report [NUM_CORES];
   logic [NUM_CORES-1:0] m_ovf;
   logic [7:0]           char_q [NUM_CORES][$];
   trace_op_e            exp_op_q [NUM_CORES][$];
   logic [DATA_W-1:0]    exp_evt_q [NUM_CORES][$];

   trace_monitor i_trace_monitor (
      .clk_i           (clk),
      .arst_n_i        (arst_n),
      .trace0_valid_i  (tr_valid[0]),
      .trace0_wben_i   (tr_wben[0]),
      .trace0_wbreg_i  (tr_wbreg[0]),
      .trace0_wbdata_i (tr_wbdata[0]),
      .trace0_pc_i     (tr_pc[0]),
      .trace0_insn_i   (tr_insn[0]),
      .trace1_valid_i  (tr_valid[1]),
      .trace1_wben_i   (tr_wben[1]),
      .trace1_wbreg_i  (tr_wbreg[1]),
      .trace1_wbdata_i (tr_wbdata[1]),
      .trace1_pc_i     (tr_pc[1]),
      .trace1_insn_i   (tr_insn[1]),
      .paddr_i         (paddr),
      .psel_i          (psel),
      .penable_i       (penable),
      .pwrite_i        (pwrite),
      .pwdata_i        (pwdata),
      .prdata_o        (prdata),
      .pslverr_o       (pslverr),
      .done_o          (done)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Completed APB transfers
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         xfer_cnt <= 0;
      end else if (psel && penable) begin
         xfer_cnt <= xfer_cnt + 1;
      end
   end

   task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
         $display("TEST FAIL");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
         $display("TEST FAIL");
         $fatal(1, "bit mismatch");
      end
   endtask

   task automatic check_op(input string name, input trace_op_e got, input trace_op_e exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %s expected %s", $time, name, got.name(),
                  exp.name());
         $display("TEST FAIL");
         $fatal(1, "op mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timed out at %0t waiting for %s", $time, what);
      $display("TEST FAIL");
      $fatal(1, "timeout");
   endtask

   // Decoder events against the queue of expected events
   task automatic check_event(input int core, input logic valid, input trace_op_e op,
                              input logic [DATA_W-1:0] data);
      if (valid) begin
         if (exp_op_q[core].size() == 0) begin
            $display("Core %0d raised an event at %0t that its trace never held", core, $time);
            $display("TEST FAIL");
            $fatal(1, "unexpected event");
         end else begin
            check_op($sformatf("evt_op_o core %0d", core), op, exp_op_q[core].pop_front());
            check_data($sformatf("evt_data_o core %0d", core), data,
                       exp_evt_q[core].pop_front());
         end
      end
   endtask

   always @(negedge clk) begin
      if (arst_n) begin
         check_event(0, i_trace_monitor.i_dec0.evt_valid_o, i_trace_monitor.i_dec0.evt_op_o,
                     i_trace_monitor.i_dec0.evt_data_o);
         check_event(1, i_trace_monitor.i_dec1.evt_valid_o, i_trace_monitor.i_dec1.evt_op_o,
                     i_trace_monitor.i_dec1.evt_data_o);
      end
   end

   function automatic logic [DATA_W-1:0] rand_word();
      return $random(seed);
   endfunction

   function automatic int rand_below(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic [DATA_W-1:0] nop_insn(input logic [15:0] imm);
      return {NOP_OPCODE, 8'h00, imm};
   endfunction

   function automatic logic [DATA_W-1:0] alu_insn();
      logic [DATA_W-1:0] w;
      w = rand_word();
      return {ALU_OPCODE, w[23:0]};
   endfunction

   // Model of one valid beat where hooks see r3 from before the beat
   function automatic void model_beat(input int core, input logic wben,
                                      input logic [REG_IDX_W-1:0] wbreg,
                                      input logic [DATA_W-1:0] wbdata,
                                      input logic [DATA_W-1:0] insn);
      if (insn[31:24] == NOP_OPCODE) begin
         if (insn[15:0] == NOP_EXIT) begin
            m_exited[core]    = 1'b1;
            m_exit_code[core] = m_r3[core];
            exp_op_q[core].push_back(OP_EXIT);
            exp_evt_q[core].push_back(m_r3[core]);
         end else if (insn[15:0] == NOP_REPORT) begin
            m_report[core] = m_r3[core];
            exp_op_q[core].push_back(OP_REPORT);
            exp_evt_q[core].push_back(m_r3[core]);
         end else if (insn[15:0] == NOP_PUTC) begin
            // Full buffer drops the character
            if (char_q[core].size() < FIFO_DEPTH) begin
               char_q[core].push_back(m_r3[core][7:0]);
            end else begin
               m_ovf[core] = 1'b1;
            end
         end
      end
      if (wben && wbreg == R3_IDX) begin
         m_r3[core] = wbdata;
      end
   endfunction

   // Register read as the model predicts it
   function automatic logic [DATA_W-1:0] model_read(input logic [7:0] addr,
                                                    output logic err);
      logic [DATA_W-1:0] word;
      word = '0;
      err  = 1'b0;
      case (addr)
         REG_STATUS: begin
            word[1:0] = m_exited;
            word[2]   = char_q[0].size() != 0;
            word[3]   = char_q[1].size() != 0;
            word[5:4] = m_ovf;
            word[8]   = &m_exited;
         end
         REG_EXIT0:   word = m_exit_code[0];
         REG_EXIT1:   word = m_exit_code[1];
         REG_REPORT0: word = m_report[0];
         REG_REPORT1: word = m_report[1];
         REG_CHAR0:   word[8:0] = char_q[0].size() ? {1'b1, char_q[0][0]} : 9'h000;
         REG_CHAR1:   word[8:0] = char_q[1].size() ? {1'b1, char_q[1][0]} : 9'h000;
         default:     err = 1'b1;
      endcase
      return word;
   endfunction

   task automatic drive_beat(input int core, input logic valid, input logic wben,
                             input logic [REG_IDX_W-1:0] wbreg,
                             input logic [DATA_W-1:0] wbdata, input logic [DATA_W-1:0] insn);
      @(negedge clk);
      tr_valid          = '0;
      tr_valid[core]    = valid;
      tr_wben[core]     = wben;
      tr_wbreg[core]    = wbreg;
      tr_wbdata[core]   = wbdata;
      tr_insn[core]     = insn;
      tr_pc[core]       = tr_pc[core] + 32'd4;
      if (valid) begin
         model_beat(core, wben, wbreg, wbdata, insn);
      end
   endtask

   task automatic settle(input int n);
      repeat (n) begin
         @(negedge clk);
         tr_valid = '0;
      end
   endtask

   task automatic write_r3(input int core, input logic [DATA_W-1:0] value);
      drive_beat(core, 1'b1, 1'b1, R3_IDX, value, alu_insn());
   endtask

   task automatic hook(input int core, input logic [15:0] imm);
      drive_beat(core, 1'b1, 1'b0, '0, '0, nop_insn(imm));
   endtask

   // Mix of r3 writes, other writes, reports, bubbles and plain l.nop
   task automatic random_beat(input int core);
      int                   kind;
      logic [REG_IDX_W-1:0] reg_idx;
      logic [DATA_W-1:0]    wdata;
      kind    = rand_below(6);
      wdata   = rand_word();
      reg_idx = wdata[REG_IDX_W-1:0];
      if (reg_idx == R3_IDX) begin
         reg_idx = reg_idx + 1'b1;
      end
      wdata = rand_word();
      case (kind)
         0: drive_beat(core, 1'b1, 1'b1, R3_IDX, wdata, alu_insn());
         1: drive_beat(core, 1'b1, 1'b1, reg_idx, wdata, alu_insn());
         2: drive_beat(core, 1'b1, 1'b0, R3_IDX, wdata, alu_insn());
         // Report beat that may write r3 itself
         3: drive_beat(core, 1'b1, wdata[0], wdata[1] ? R3_IDX : reg_idx, wdata,
                       nop_insn(NOP_REPORT));
         4: drive_beat(core, 1'b0, 1'b1, R3_IDX, wdata, nop_insn(NOP_REPORT));
         default: drive_beat(core, 1'b1, 1'b0, R3_IDX, wdata, nop_insn(16'h0003));
      endcase
   endtask

   // Samples the access phase, then waits for the bus to complete it
   task automatic apb_finish(output logic [DATA_W-1:0] data, output logic err);
      int start;
      int cnt;
      start = xfer_cnt;
      cnt   = 0;
      #1;
      data = prdata;
      err  = pslverr;
      while (xfer_cnt == start && cnt < APB_TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      psel    = 1'b0;
      penable = 1'b0;
      if (xfer_cnt == start) report_timeout("APB transfer to complete");
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [DATA_W-1:0] data,
                           output logic err);
      @(negedge clk);
      tr_valid = '0;
      paddr    = addr;
      pwrite   = 1'b0;
      psel     = 1'b1;
      penable  = 1'b0;
      @(negedge clk);
      penable = 1'b1;
      apb_finish(data, err);
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [DATA_W-1:0] wdata,
                            output logic err);
      logic [DATA_W-1:0] unused;
      @(negedge clk);
      tr_valid = '0;
      paddr    = addr;
      pwdata   = wdata;
      pwrite   = 1'b1;
      psel     = 1'b1;
      penable  = 1'b0;
      @(negedge clk);
      penable = 1'b1;
      apb_finish(unused, err);
   endtask

   task automatic read_and_check(input logic [7:0] addr);
      logic [DATA_W-1:0] exp;
      logic [DATA_W-1:0] got;
      logic              exp_err;
      logic              got_err;
      exp = model_read(addr, exp_err);
      apb_read(addr, got, got_err);
      check_bit($sformatf("pslverr_o on read of %h", addr), got_err, exp_err);
      if (!exp_err) begin
         check_data($sformatf("prdata_o at %h", addr), got, exp);
      end
      // CHARn read pops a buffered character
      if (addr == REG_CHAR0 && char_q[0].size() != 0) void'(char_q[0].pop_front());
      if (addr == REG_CHAR1 && char_q[1].size() != 0) void'(char_q[1].pop_front());
   endtask

   task automatic write_and_check(input logic [7:0] addr, input logic [DATA_W-1:0] wdata);
      logic err;
      apb_write(addr, wdata, err);
      check_bit($sformatf("pslverr_o on write to %h", addr), err, addr != REG_STATUS);
      // Write 1 clears overflow
      if (addr == REG_STATUS) m_ovf = m_ovf & ~wdata[5:4];
   endtask

   task automatic check_all_regs();
      for (int a = 0; a <= 'h18; a += 4) begin
         read_and_check(8'(a));
      end
   endtask

   initial begin
      logic [7:0]        addr;
      logic [DATA_W-1:0] w;
      seed     = 32'h1e37_f81b;
      arst_n   = 1'b0;
      tr_valid = '0;
      tr_wben  = '0;
      paddr    = '0;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      pwdata   = '0;
      m_exited = '0;
      m_ovf    = '0;
      for (int c = 0; c < NUM_CORES; c++) begin
         tr_wbreg[c]    = '0;
         tr_wbdata[c]   = '0;
         tr_pc[c]       = 32'h0000_0100 * (c + 1);
         tr_insn[c]     = '0;
         m_r3[c]        = '0;
         m_exit_code[c] = '0;
         m_report[c]    = '0;
      end
      repeat (2) @(negedge clk);
      arst_n = 1'b1;

      // Everything reads zero after reset
      check_bit("done_o", done, 1'b0);
      check_all_regs();

      // Random traces with report hooks
      for (int round = 0; round < 8; round++) begin
         for (int i = 0; i < 12; i++) begin
            random_beat(rand_below(NUM_CORES));
         end
         settle(3);
         read_and_check(REG_REPORT0);
         read_and_check(REG_REPORT1);
      end

      // Short putc runs followed by one read past the end
      for (int c = 0; c < NUM_CORES; c++) begin
         for (int n = 1; n < FIFO_DEPTH; n++) begin
            for (int i = 0; i < n; i++) begin
               write_r3(c, rand_word());
               hook(c, NOP_PUTC);
            end
            settle(3);
            read_and_check(REG_STATUS);
            for (int i = 0; i <= n; i++) begin
               read_and_check(c ? REG_CHAR1 : REG_CHAR0);
            end
            read_and_check(REG_STATUS);
         end
      end

      // Overrun the buffer, drain it and clear the flag
      for (int c = 0; c < NUM_CORES; c++) begin
         for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            write_r3(c, rand_word());
            hook(c, NOP_PUTC);
         end
         settle(3);
         read_and_check(REG_STATUS);
         for (int i = 0; i <= FIFO_DEPTH; i++) begin
            read_and_check(c ? REG_CHAR1 : REG_CHAR0);
         end
         write_and_check(REG_STATUS, 32'h1 << (4 + c));
         read_and_check(REG_STATUS);
      end

      // One exit keeps done low, the second raises it
      write_r3(0, rand_word());
      hook(0, NOP_EXIT);
      settle(3);
      read_and_check(REG_STATUS);
      read_and_check(REG_EXIT0);
      check_bit("done_o", done, 1'b0);
      write_r3(1, rand_word());
      hook(1, NOP_EXIT);
      begin : wait_for_done
         int cnt;
         cnt = 0;
         while (done !== 1'b1 && cnt < DONE_TIMEOUT) begin
            @(negedge clk);
            tr_valid = '0;
            cnt++;
         end
         if (done !== 1'b1) report_timeout("done_o to rise");
      end
      settle(2);
      read_and_check(REG_STATUS);
      read_and_check(REG_EXIT1);
      // A later exit replaces the code
      write_r3(0, rand_word());
      hook(0, NOP_EXIT);
      settle(3);
      read_and_check(REG_EXIT0);

      // Erroring transfers must keep the core 0 overflow flag and the core 1 character
      for (int i = 0; i <= FIFO_DEPTH; i++) begin
         write_r3(0, rand_word());
         hook(0, NOP_PUTC);
      end
      write_r3(1, rand_word());
      hook(1, NOP_PUTC);
      settle(3);
      read_and_check(REG_STATUS);
      for (int i = 0; i < 16; i++) begin
         do begin
            w    = rand_word();
            addr = w[7:0];
         end while (addr[1:0] == 2'b00 && addr <= 8'h18);
         read_and_check(addr);
         write_and_check(addr, rand_word());
         write_and_check(8'(4 + 4 * rand_below(6)), rand_word());
      end
      check_all_regs();

      settle(3);
      check_data("pending events core 0", exp_op_q[0].size(), 0);
      check_data("pending events core 1", exp_op_q[1].size(), 0);
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
hdl/trace_pkg.sv
hdl/char_fifo.sv
hdl/core_trace_decoder.sv
hdl/trace_apb_regs.sv
hdl/trace_monitor.sv
verif/tb_trace_monitor.sv

/* Bender.yml */
package:
  name: trace_monitor

sources:
  # RTL in compile order
  - files:
      - hdl/trace_pkg.sv
      - hdl/char_fifo.sv
      - hdl/core_trace_decoder.sv
      - hdl/trace_apb_regs.sv
      - hdl/trace_monitor.sv

  # Testbench
  - target: simulation
    files:
      - verif/tb_trace_monitor.sv
